// File: hw/video_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module video_fetch
	import video_pkg::*;
(
	input wire clk,
	input wire ss,
	input wire fetch_window,
	input wire frame_end,
	input wire [3:0] bus_cycle,
	input wire [15:0] data,
	input wire [ADDR_W-1:0] base_addr,
	output logic read,
	output logic [ADDR_W-1:0] vaddr,
	output logic [15:0] word
);

	logic capture;

	// video owns bus cycles 0..3 of every 16
	// one word per slot, 40 slots per active line
	assign read = fetch_window && (bus_cycle[3:2] == 2'b00);

	// memory data valid on the last video bus cycle
	assign capture = read && (bus_cycle == 4'd3);

	// video address counter
	// steps once per fetched word
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			// same value the base register resets to
			vaddr <= BASE_ADDR_RST;
		end else if (capture) begin
			vaddr <= vaddr + ADDR_W'(1);
		end else if (frame_end) begin
			// next frame starts at the current base
			// a new base written in vblank applies here
			vaddr <= base_addr;
		end
	end

	// word holding register
	// stays put until the pixel shifter reloads at slot end
	always_ff @(posedge clk) begin
		if (capture) begin
			word <= data;
		end
	end

endmodule

`default_nettype wire

// File: hw/video_pixel.sv
`timescale 1ns/1ns
`default_nettype none

module video_pixel (
	input wire clk,
	input wire ss,
	input wire de,
	input wire hs_raw,
	input wire vs_raw,
	input wire pal0_blue_lsb,
	input wire [9:0] hcnt,
	input wire [15:0] word,
	output logic [5:0] video_r,
	output logic [5:0] video_g,
	output logic [5:0] video_b,
	output logic hs,
	output logic vs
);

	logic [15:0] shreg;
	logic pix;
	logic [5:0] level;

	// shifter reload at end of each 16 clock slot
	// msb first, one pixel per clock
	always_ff @(posedge clk) begin
		if (hcnt[3:0] == 4'hf) begin
			shreg <= word;
		end else begin
			shreg <= {shreg[14:0], 1'b0};
		end
	end

	// palette 0 blue lsb flips black and white
	assign pix = shreg[15] ^ pal0_blue_lsb;

	// full white or black, blanked outside de
	assign level = (de && pix) ? 6'h3f : 6'h00;

	// output stage, one clock behind the raster
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			video_r <= 6'h00;
			video_g <= 6'h00;
			video_b <= 6'h00;
			hs <= 1'b1;
			vs <= 1'b1;
		end else begin
			// grey scale, same level on all channels
			video_r <= level;
			video_g <= level;
			video_b <= level;
			// mono monitor wants negative syncs
			hs <= ~hs_raw;
			vs <= ~vs_raw;
		end
	end

endmodule

`default_nettype wire

// File: hw/video_pkg.sv
`default_nettype none

package video_pkg;

	// monochrome raster, one clock per pixel
	// horizontal timing in clocks
	localparam logic [9:0] H_ACT = 10'd640;
	// words are fetched 16 clocks ahead of display
	localparam logic [9:0] H_PRE = 10'd16;
	localparam logic [9:0] H_FP = 10'd24;
	localparam logic [9:0] H_SYNC = 10'd40;
	localparam logic [9:0] H_BP = 10'd128;
	// 832 clocks per line
	localparam logic [9:0] H_TOT = H_ACT + H_FP + H_SYNC + H_BP;

	// vertical timing in lines
	localparam logic [9:0] V_ACT = 10'd400;
	localparam logic [9:0] V_FP = 10'd55;
	localparam logic [9:0] V_SYNC = 10'd3;
	localparam logic [9:0] V_BP = 10'd73;
	// 531 lines per frame, about 72 Hz
	localparam logic [9:0] V_TOT = V_ACT + V_FP + V_SYNC + V_BP;

	// video memory word address
	localparam int ADDR_W = 23;

	// base address after reset
	localparam logic [ADDR_W-1:0] BASE_ADDR_RST = 23'h8000;

	// palette entry 0 after reset, packed as red, green, blue
	// blue bit 0 set so the mono picture comes up inverted
	localparam logic [8:0] PAL0_RST = {3'b000, 3'b000, 3'b111};

	// cpu register map
	typedef enum logic [5:0] {
		REG_BASE_HI = 6'h00,
		REG_BASE_LO = 6'h01,
		REG_VADDR_HI = 6'h02,
		REG_VADDR_MID = 6'h03,
		REG_VADDR_LO = 6'h04,
		REG_PALETTE0 = 6'h20
	} reg_addr_e;

endpackage

`default_nettype wire

// File: hw/video_regs.sv
`timescale 1ns/1ns
`default_nettype none

module video_regs
	import video_pkg::*;
(
	input wire clk,
	input wire ss,
	input wire reg_sel,
	input wire reg_rw,
	input wire reg_uds,
	input wire reg_lds,
	input wire [5:0] reg_addr,
	input wire [15:0] reg_din,
	input wire [ADDR_W-1:0] vaddr,
	output logic [15:0] reg_dout,
	output logic [ADDR_W-1:0] base_addr,
	output logic pal0_blue_lsb
);

	reg_addr_e addr;
	logic wr_en;
	logic rd_en;
	// base address bits 22:7, the low bits are fixed zero
	logic [15:0] base_q;
	logic [2:0] pal_r;
	logic [2:0] pal_g;
	logic [2:0] pal_b;

	assign addr = reg_addr_e'(reg_addr);

	// reg_rw high means cpu read
	assign wr_en = reg_sel && !reg_rw;
	assign rd_en = reg_sel && reg_rw;

	// byte lane writes, strobes are active low
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			base_q <= BASE_ADDR_RST[ADDR_W-1:7];
			{pal_r, pal_g, pal_b} <= PAL0_RST;
		end else if (wr_en) begin
			case (addr)
				REG_BASE_HI: begin
					if (!reg_lds) begin
						base_q[15:8] <= reg_din[7:0];
					end
				end
				REG_BASE_LO: begin
					if (!reg_lds) begin
						base_q[7:0] <= reg_din[7:0];
					end
				end
				REG_PALETTE0: begin
					// red sits in the upper byte
					if (!reg_uds) begin
						pal_r <= reg_din[10:8];
					end
					if (!reg_lds) begin
						pal_g <= reg_din[6:4];
						pal_b <= reg_din[2:0];
					end
				end
				// vaddr registers are read only
				default: begin
				end
			endcase
		end
	end

	assign base_addr = {base_q, 7'b0000000};

	// mono inversion bit
	assign pal0_blue_lsb = pal_b[0];

	// readback mux
	// zero unless selected, mapped and lane enabled
	always_comb begin
		reg_dout = 16'h0000;
		if (rd_en) begin
			case (addr)
				REG_BASE_HI: if (!reg_lds) reg_dout[7:0] = base_q[15:8];
				REG_BASE_LO: if (!reg_lds) reg_dout[7:0] = base_q[7:0];
				REG_VADDR_HI: if (!reg_lds) reg_dout[7:0] = vaddr[22:15];
				REG_VADDR_MID: if (!reg_lds) reg_dout[7:0] = vaddr[14:7];
				// word address lands on byte address bits 7:1
				REG_VADDR_LO: if (!reg_lds) reg_dout[7:0] = {vaddr[6:0], 1'b0};
				REG_PALETTE0: begin
					if (!reg_uds) begin
						reg_dout[10:8] = pal_r;
					end
					if (!reg_lds) begin
						reg_dout[6:4] = pal_g;
						reg_dout[2:0] = pal_b;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/video_timing.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing
	import video_pkg::*;
(
	input wire clk,
	input wire ss,
	output logic [9:0] hcnt,
	output logic [9:0] vcnt,
	output logic de,
	output logic fetch_window,
	output logic frame_end,
	output logic hs_raw,
	output logic vs_raw
);

	logic h_last;
	logic v_last;

	// last clock of a line / last line of a frame
	assign h_last = (hcnt == H_TOT - 10'd1);
	assign v_last = (vcnt == V_TOT - 10'd1);

	// raster counters
	// reset also lines hcnt up with the bus cycle counter
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			hcnt <= 10'd0;
			vcnt <= 10'd0;
		end else begin
			if (h_last) begin
				hcnt <= 10'd0;
				// line wrap steps the vertical counter
				if (v_last) begin
					vcnt <= 10'd0;
				end else begin
					vcnt <= vcnt + 10'd1;
				end
			end else begin
				hcnt <= hcnt + 10'd1;
			end
		end
	end

	// display enable
	// trails the fetch window by the prefetch distance
	assign de = (hcnt >= H_PRE) &&
		(hcnt < H_ACT + H_PRE) &&
		(vcnt < V_ACT);

	// memory is read over the first 640 clocks of active lines
	assign fetch_window = (hcnt < H_ACT) && (vcnt < V_ACT);

	// hsync right after front porch
	assign hs_raw = (hcnt >= H_ACT + H_FP) &&
		(hcnt < H_ACT + H_FP + H_SYNC);

	// vsync lines after the vertical front porch
	assign vs_raw = (vcnt >= V_ACT + V_FP) &&
		(vcnt < V_ACT + V_FP + V_SYNC);

	// single clock strobe well clear of the active area
	// used to restart the video address counter
	assign frame_end = (hcnt == H_ACT + H_FP + H_PRE) &&
		(vcnt == V_ACT + V_FP);

endmodule

`default_nettype wire

// File: hw/video_top.sv
`timescale 1ns/1ns
`default_nettype none

module video_top
	import video_pkg::*;
(
	input wire clk,
	input wire ss,
	// bus slot counter, equals hcnt[3:0]
	input wire [3:0] bus_cycle,
	input wire [15:0] data,
	// cpu port
	input wire reg_sel,
	input wire reg_rw,
	input wire reg_uds,
	input wire reg_lds,
	input wire [5:0] reg_addr,
	input wire [15:0] reg_din,
	// memory side
	output logic read,
	output logic [ADDR_W-1:0] vaddr,
	output logic [15:0] reg_dout,
	// monitor side
	output logic [5:0] video_r,
	output logic [5:0] video_g,
	output logic [5:0] video_b,
	output logic hs,
	output logic vs
);

	logic [9:0] hcnt;
	logic de;
	logic fetch_window;
	logic frame_end;
	logic hs_raw;
	logic vs_raw;
	logic [ADDR_W-1:0] base_addr;
	logic pal0_blue_lsb;
	logic [15:0] word;

	// raster generator
	// vcnt is only decoded inside the timing block
	video_timing u_timing (
		.clk(clk),
		.ss(ss),
		.hcnt(hcnt),
		.vcnt(),
		.de(de),
		.fetch_window(fetch_window),
		.frame_end(frame_end),
		.hs_raw(hs_raw),
		.vs_raw(vs_raw)
	);

	// cpu registers
	video_regs u_regs (
		.clk(clk),
		.ss(ss),
		.reg_sel(reg_sel),
		.reg_rw(reg_rw),
		.reg_uds(reg_uds),
		.reg_lds(reg_lds),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.vaddr(vaddr),
		.reg_dout(reg_dout),
		.base_addr(base_addr),
		.pal0_blue_lsb(pal0_blue_lsb)
	);

	// memory fetch and address counter
	video_fetch u_fetch (
		.clk(clk),
		.ss(ss),
		.fetch_window(fetch_window),
		.frame_end(frame_end),
		.bus_cycle(bus_cycle),
		.data(data),
		.base_addr(base_addr),
		.read(read),
		.vaddr(vaddr),
		.word(word)
	);

	// shifter and output registers
	video_pixel u_pixel (
		.clk(clk),
		.ss(ss),
		.de(de),
		.hs_raw(hs_raw),
		.vs_raw(vs_raw),
		.pal0_blue_lsb(pal0_blue_lsb),
		.hcnt(hcnt),
		.word(word),
		.video_r(video_r),
		.video_g(video_g),
		.video_b(video_b),
		.hs(hs),
		.vs(vs)
	);

endmodule

`default_nettype wire

// File: list.f
hw/video_pkg.sv
hw/video_timing.sv
hw/video_regs.sv
hw/video_fetch.sv
hw/video_pixel.sv
hw/video_top.sv
tb/tb_video.sv

// File: run.sh
#!/usr/bin/env bash
# build the video testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
	--top-module tb_video -o tb_video -f list.f &&
	./obj_dir/tb_video | tee /dev/stderr | grep -qxF '** PASS **' &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// File: tb/tb_video.sv
`timescale 1ns/1ns
`default_nettype none

module tb_video;

	// three frames of 832 x 531 clocks, limit at four
	localparam int FRAMES = 3;
	localparam int MAX_CYCLES = (FRAMES + 1) * 832 * 531;
	localparam logic [31:0] SEED = 32'h149da14a;
	// mapped register addresses
	localparam logic [5:0] MAP_ADDR [6] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h20};
	// readback after reset, base 0x8000 and vaddr equal to it, blue 7
	localparam logic [15:0] DEF_DOUT [6] = '{16'h0001, 16'h0000, 16'h0001, 16'h0000,
		16'h0000, 16'h0007};

	logic clk;
	logic ss;
	logic [3:0] bus_cycle;
	logic [15:0] data;
	logic reg_sel;
	logic reg_rw;
	logic reg_uds;
	logic reg_lds;
	logic [5:0] reg_addr;
	logic [15:0] reg_din;
	logic read;
	logic [22:0] vaddr;
	logic [15:0] reg_dout;
	logic [5:0] video_r;
	logic [5:0] video_g;
	logic [5:0] video_b;
	logic hs;
	logic vs;

	// raster position of the current cycle, and of the one before
	int h;
	int v;
	int frame;
	int ph;
	int pv;
	logic p_valid;
	logic p_inv;
	logic [22:0] p_base;
	// register and address counter mirror
	logic [22:0] m_base;
	logic [22:0] m_vaddr;
	logic [22:0] m_frame_base;
	logic [2:0] m_pal_r;
	logic [2:0] m_pal_g;
	logic [2:0] m_pal_b;
	// cpu access of the current cycle
	logic acc_valid;
	logic acc_rw;
	logic acc_uds;
	logic acc_lds;
	logic [5:0] acc_addr;
	logic [15:0] acc_din;
	logic [31:0] rng;
	int errors;
	int checks;
	int n_read;
	int n_hs;
	int n_vs;
	int cycles = 0;

	video_top uut (
		.clk(clk),
		.ss(ss),
		.bus_cycle(bus_cycle),
		.data(data),
		.reg_sel(reg_sel),
		.reg_rw(reg_rw),
		.reg_uds(reg_uds),
		.reg_lds(reg_lds),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.read(read),
		.vaddr(vaddr),
		.reg_dout(reg_dout),
		.video_r(video_r),
		.video_g(video_g),
		.video_b(video_b),
		.hs(hs),
		.vs(vs)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// video memory, a hash over the whole word address
	function automatic logic [15:0] mem_word(input logic [22:0] a);
		logic [31:0] x;
		x = {9'd0, a} * 32'h9e3779b1;
		return x[31:16] ^ x[15:0];
	endfunction

	// combinational memory answer
	assign data = mem_word(vaddr);

	// readback per register map, zero for lanes off or unmapped
	function automatic logic [15:0] exp_dout(input logic [5:0] a, input logic uds,
		input logic lds);
		logic [15:0] d;
		d = 16'h0000;
		if (a == 6'h00 && !lds) d[7:0] = m_base[22:15];
		if (a == 6'h01 && !lds) d[7:0] = m_base[14:7];
		if (a == 6'h02 && !lds) d[7:0] = m_vaddr[22:15];
		if (a == 6'h03 && !lds) d[7:0] = m_vaddr[14:7];
		// word address shows as byte address, bit 0 zero
		if (a == 6'h04 && !lds) d[7:0] = {m_vaddr[6:0], 1'b0};
		if (a == 6'h20) begin
			if (!uds) d[10:8] = m_pal_r;
			if (!lds) d[6:4] = m_pal_g;
			if (!lds) d[2:0] = m_pal_b;
		end
		return d;
	endfunction

	// pixel of the previous cycle, 40 words per line from the frame base
	function automatic logic [5:0] exp_level();
		int col;
		logic [15:0] w;
		logic b;
		if (!p_valid || pv >= 400 || ph < 16 || ph >= 656) return 6'h00;
		col = ph - 16;
		w = mem_word(p_base + 23'(pv * 40 + col / 16));
		b = w[15 - (col % 16)] ^ p_inv;
		return b ? 6'h3f : 6'h00;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// pick and drive this cycle's cpu access
	task automatic drive_access();
		logic [31:0] r;
		rng = xorshift(rng);
		r = rng;
		acc_valid = 1'b0;
		acc_rw = 1'b1;
		acc_uds = 1'b1;
		acc_lds = 1'b1;
		acc_addr = 6'h00;
		acc_din = 16'h0000;
		if (frame == 0 && v == 456 && h < 6) begin
			// defaults, vaddr has just reloaded from base
			acc_valid = 1'b1;
			acc_addr = MAP_ADDR[h];
			acc_uds = 1'b0;
			acc_lds = 1'b0;
		end else if (v == 530 && h == 831 && frame < FRAMES - 1) begin
			// inversion off for frame 1, on again for frame 2
			acc_valid = 1'b1;
			acc_rw = 1'b0;
			acc_addr = 6'h20;
			acc_uds = r[8];
			acc_lds = 1'b0;
			acc_din = {r[31:17], 1'(frame % 2)};
		end else if (v >= 400 && (frame > 0 || v > 456) && r[2:0] == 3'd0) begin
			// random traffic in vblank only
			acc_valid = 1'b1;
			acc_rw = r[3];
			acc_uds = r[4];
			acc_lds = r[5];
			acc_addr = r[6] ? MAP_ADDR[int'(r[9:7]) % 6] : r[15:10];
			acc_din = r[31:16];
		end
		reg_sel = acc_valid;
		reg_rw = acc_rw;
		reg_uds = acc_uds;
		reg_lds = acc_lds;
		reg_addr = acc_addr;
		reg_din = acc_din;
	endtask

	// sampled mid cycle, all outputs settled
	task automatic check_outputs();
		logic [5:0] lvl;
		logic exp_read;
		logic [22:0] end_addr;
		lvl = exp_level();
		exp_read = (h < 640) && (v < 400) && (h % 16 < 4);
		end_addr = m_frame_base + 23'd16000;
		check("read", 32'(read), 32'(exp_read));
		check("vaddr", 32'(vaddr), 32'(m_vaddr));
		// 400 lines of 40 words each before the reload
		if (h == 680 && v == 455) check("vaddr_frame_end", 32'(vaddr), 32'(end_addr));
		if (acc_valid && acc_rw) begin
			check("reg_dout", 32'(reg_dout), 32'(exp_dout(acc_addr, acc_uds, acc_lds)));
		end else begin
			check("reg_dout", 32'(reg_dout), 32'd0);
		end
		if (frame == 0 && v == 456 && h < 6) begin
			check("reg_dout_reset", 32'(reg_dout), 32'(DEF_DOUT[h]));
		end
		check("video_r", 32'(video_r), 32'(lvl));
		check("video_g", 32'(video_g), 32'(lvl));
		check("video_b", 32'(video_b), 32'(lvl));
		// negative syncs, one clock late
		check("hs", 32'(hs), 32'(!(p_valid && ph >= 664 && ph < 704)));
		check("vs", 32'(vs), 32'(!(p_valid && pv >= 455 && pv < 458)));
		if (read) n_read++;
		if (!hs) n_hs++;
		if (!vs) n_vs++;
	endtask

	// follow the clock edge just taken
	task automatic step_model();
		p_valid = 1'b1;
		ph = h;
		pv = v;
		p_inv = m_pal_b[0];
		p_base = m_frame_base;
		if (h < 640 && v < 400 && h % 16 == 3) begin
			m_vaddr = m_vaddr + 23'd1;
		end else if (h == 680 && v == 455) begin
			// next frame starts from the base as it stands now
			m_vaddr = m_base;
			m_frame_base = m_base;
		end
		if (acc_valid && !acc_rw) begin
			if (acc_addr == 6'h00 && !acc_lds) m_base[22:15] = acc_din[7:0];
			if (acc_addr == 6'h01 && !acc_lds) m_base[14:7] = acc_din[7:0];
			if (acc_addr == 6'h20 && !acc_uds) m_pal_r = acc_din[10:8];
			if (acc_addr == 6'h20 && !acc_lds) m_pal_g = acc_din[6:4];
			if (acc_addr == 6'h20 && !acc_lds) m_pal_b = acc_din[2:0];
		end
		if (h == 831) begin
			h = 0;
			if (v == 530) begin
				// per frame totals
				check("read_per_frame", 32'(n_read), 32'd64000);
				check("hs_low_per_frame", 32'(n_hs), 32'(40 * 531));
				check("vs_low_per_frame", 32'(n_vs), 32'(3 * 832));
				n_read = 0;
				n_hs = 0;
				n_vs = 0;
				v = 0;
				frame++;
			end else begin
				v++;
			end
		end else begin
			h++;
		end
		bus_cycle = bus_cycle + 4'd1;
	endtask

	initial begin
		clk = 1'b0;
		ss = 1'b1;
		bus_cycle = 4'd0;
		reg_sel = 1'b0;
		reg_rw = 1'b1;
		reg_uds = 1'b1;
		reg_lds = 1'b1;
		reg_addr = 6'h00;
		reg_din = 16'h0000;
		rng = SEED;
		errors = 0;
		checks = 0;
		n_read = 0;
		n_hs = 0;
		n_vs = 0;
		h = 0;
		v = 0;
		frame = 0;
		ph = 0;
		pv = 0;
		p_valid = 1'b0;
		p_inv = 1'b1;
		m_base = 23'h8000;
		m_vaddr = 23'h8000;
		m_frame_base = 23'h8000;
		p_base = 23'h8000;
		m_pal_r = 3'd0;
		m_pal_g = 3'd0;
		m_pal_b = 3'd7;
		acc_valid = 1'b0;
		acc_rw = 1'b1;
		acc_uds = 1'b1;
		acc_lds = 1'b1;
		acc_addr = 6'h00;
		acc_din = 16'h0000;
		repeat (4) @(posedge clk);
		#1;
		// release lines hcnt 0 up with bus_cycle 0
		ss = 1'b0;
		while (frame < FRAMES) begin
			drive_access();
			@(negedge clk);
			check_outputs();
			@(posedge clk);
			#1;
			step_model();
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

`default_nettype wire
